// File: source/hub_settings.svh
`ifndef HUB_SETTINGS_SVH
`define HUB_SETTINGS_SVH

// link count toward the leaf boards
`define HUB_DOWN_COUNT 4

// message field widths
`define HUB_FPGA_ID_WIDTH 4
`define HUB_FIFO_ID_WIDTH 2
`define HUB_ADDRESS_WIDTH 6
`define HUB_MSG_WIDTH 24

// direct flag, odd-cardinality flag and boundary flag
`define HUB_FLAG_BITS 3
`define HUB_PAYLOAD_WIDTH (`HUB_MSG_WIDTH - `HUB_FPGA_ID_WIDTH - `HUB_FIFO_ID_WIDTH \
    - `HUB_ADDRESS_WIDTH - `HUB_FLAG_BITS)

// words held by each input buffer
`define HUB_BUF_DEPTH 8

// downstream port k owns ids FIRST + k*IDS_PER_PORT and the next ones
`define HUB_FIRST_PORT_ID 1
`define HUB_IDS_PER_PORT 2

`endif

// File: source/hub_msg_pkg.sv
`include "hub_settings.svh"

package hub_msg_pkg;

    // message as it travels on every link, msb first
    typedef struct packed {
        logic [`HUB_FPGA_ID_WIDTH-1:0] dest_fpga_id;
        // all ones marks a stage controller message
        logic [`HUB_FIFO_ID_WIDTH-1:0] fifo_id;
        logic [`HUB_PAYLOAD_WIDTH-1:0] payload;
        // carried through, routed like any other message
        logic                          direct;
        logic [`HUB_ADDRESS_WIDTH-1:0] address;
        logic                          odd_cardinality;
        logic                          boundary;
    } hub_msg_t;

    // where the selected message came from
    typedef enum logic [1:0] {
        ORIGIN_NONE,
        ORIGIN_UP,
        ORIGIN_DOWN
    } hub_origin_e;

endpackage

// File: source/hub_route_pkg.sv
`include "hub_settings.svh"

package hub_route_pkg;

    // how the router treats a selected message
    typedef enum logic [1:0] {
        ROUTE_BCAST_DOWN,
        ROUTE_CTRL_UP,
        ROUTE_BY_ID
    } hub_route_e;

    // one bit per downstream port, top bit is the upstream link
    typedef logic [`HUB_DOWN_COUNT:0] hub_dest_t;

    // one-hot port owning the id, upstream when nobody owns it
    function automatic hub_dest_t port_for_id(input logic [`HUB_FPGA_ID_WIDTH-1:0] id);
        hub_dest_t dest;
        int unsigned lo;
        dest = '0;
        for (int k = 0; k < `HUB_DOWN_COUNT; k++) begin
            lo = `HUB_FIRST_PORT_ID + k * `HUB_IDS_PER_PORT;
            if (id >= lo && id < lo + `HUB_IDS_PER_PORT) begin
                dest[k] = 1'b1;
            end
        end
        if (dest == '0) begin
            dest[`HUB_DOWN_COUNT] = 1'b1;
        end
        return dest;
    endfunction

endpackage

// File: source/hub_sel_if.sv
// selected message handed from the arbiter to the router
interface hub_sel_if;

    hub_msg_pkg::hub_msg_t    msg;
    hub_msg_pkg::hub_origin_e origin;
    logic                     valid;

    // high when every output link can take a word
    logic                     ready;

    modport arb_mp (
        output msg,
        output origin,
        output valid,
        input  ready
    );

    modport rtr_mp (
        input  msg,
        input  origin,
        input  valid,
        output ready
    );

endinterface

// File: source/hub_input_buffer.sv
`include "hub_settings.svh"

module hub_input_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  hub_msg_pkg::hub_msg_t in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output hub_msg_pkg::hub_msg_t out_data,
    output logic                  out_valid,
    input  logic                  out_taken,
    output logic                  empty
);

    localparam int DEPTH = `HUB_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    hub_msg_pkg::hub_msg_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign out_valid = ~empty;
    assign out_data  = mem[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_taken & out_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/hub_arbiter.sv
`include "hub_settings.svh"

module hub_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  hub_msg_pkg::hub_msg_t     up_data,
    input  logic                      up_valid,
    output logic                      up_taken,
    input  hub_msg_pkg::hub_msg_t     down_data [`HUB_DOWN_COUNT],
    input  logic [`HUB_DOWN_COUNT-1:0] down_valid,
    output logic [`HUB_DOWN_COUNT-1:0] down_taken,
    hub_sel_if.arb_mp                 sel
);

    localparam int DOWN   = `HUB_DOWN_COUNT;
    localparam int IDX_W  = (DOWN > 1) ? $clog2(DOWN) : 1;
    localparam int LEAVES = 2 ** IDX_W;
    localparam int NODES  = 2 * LEAVES - 1;

    // heap ordered tree, node n has children 2n+1 and 2n+2, root is node 0
    wire                        node_valid [NODES];
    wire [IDX_W-1:0]            node_idx   [NODES];
    wire hub_msg_pkg::hub_msg_t node_msg   [NODES];

    for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
        if (i < DOWN) begin : g_used
            assign node_valid[LEAVES-1+i] = down_valid[i];
            assign node_idx[LEAVES-1+i]   = IDX_W'(i);
            assign node_msg[LEAVES-1+i]   = down_data[i];
        end else begin : g_pad
            assign node_valid[LEAVES-1+i] = 1'b0;
            assign node_idx[LEAVES-1+i]   = '0;
            assign node_msg[LEAVES-1+i]   = '0;
        end
    end

    // left child holds the lower port numbers, so it wins
    for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
        assign node_valid[n] = node_valid[2*n+1] | node_valid[2*n+2];
        assign node_idx[n]   = node_valid[2*n+1] ? node_idx[2*n+1] : node_idx[2*n+2];
        assign node_msg[n]   = node_valid[2*n+1] ? node_msg[2*n+1] : node_msg[2*n+2];
    end

    // upstream head always goes first
    assign up_taken = sel.ready & up_valid;

    always_comb begin
        for (int i = 0; i < DOWN; i++) begin
            down_taken[i] = sel.ready & ~up_valid & node_valid[0]
                          & (node_idx[0] == IDX_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (sel.ready) begin
            sel.msg <= up_valid ? up_data : node_msg[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel.valid  <= 1'b0;
            sel.origin <= hub_msg_pkg::ORIGIN_NONE;
        end else if (sel.ready) begin
            if (up_valid) begin
                sel.valid  <= 1'b1;
                sel.origin <= hub_msg_pkg::ORIGIN_UP;
            end else if (node_valid[0]) begin
                sel.valid  <= 1'b1;
                sel.origin <= hub_msg_pkg::ORIGIN_DOWN;
            end else begin
                sel.valid  <= 1'b0;
                sel.origin <= hub_msg_pkg::ORIGIN_NONE;
            end
        end
    end

endmodule

// File: source/hub_router.sv
`include "hub_settings.svh"

module hub_router (
    input  logic                       clk,
    input  logic                       rst_n,
    hub_sel_if.rtr_mp                  sel,
    input  logic                       all_ready,
    output hub_msg_pkg::hub_msg_t      out_msg,
    output hub_route_pkg::hub_dest_t   out_dest,
    input  logic [`HUB_DOWN_COUNT-1:0] down_odd,
    input  logic [`HUB_DOWN_COUNT-1:0] down_flying,
    input  logic                       hub_busy,
    output logic                       up_odd,
    output logic                       up_flying
);

    localparam int DOWN = `HUB_DOWN_COUNT;

    hub_route_pkg::hub_route_e route;
    hub_route_pkg::hub_dest_t  dest;
    logic                      is_ctrl;

    // selection only moves when every output can take the word
    assign sel.ready = all_ready;

    assign is_ctrl = (sel.msg.fifo_id == '1);

    // control traffic depends on direction, the rest goes by fpga id
    always_comb begin
        route = hub_route_pkg::ROUTE_BY_ID;
        if (is_ctrl) begin
            if (sel.origin == hub_msg_pkg::ORIGIN_UP) begin
                route = hub_route_pkg::ROUTE_BCAST_DOWN;
            end else if (sel.origin == hub_msg_pkg::ORIGIN_DOWN) begin
                route = hub_route_pkg::ROUTE_CTRL_UP;
            end
        end
    end

    always_comb begin
        case (route)
            hub_route_pkg::ROUTE_BCAST_DOWN: begin
                dest = {1'b0, {DOWN{1'b1}}};
            end
            hub_route_pkg::ROUTE_CTRL_UP: begin
                dest = {1'b1, {DOWN{1'b0}}};
            end
            default: begin
                dest = hub_route_pkg::port_for_id(sel.msg.dest_fpga_id);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (all_ready) begin
            out_msg <= sel.msg;
        end
    end

    // one mask for every output, so a broadcast leaves as a single transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_dest <= '0;
        end else if (all_ready) begin
            out_dest <= sel.valid ? dest : '0;
        end
    end

    // status toward the stage controller
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_odd    <= 1'b0;
            up_flying <= 1'b0;
        end else begin
            up_odd    <= |down_odd;
            up_flying <= (|down_flying) | hub_busy;
        end
    end

endmodule

// File: source/fpga_hub.sv
`include "hub_settings.svh"

module fpga_hub (
    input  logic                                    clk,
    input  logic                                    rst_n,

    input  logic [`HUB_MSG_WIDTH-1:0]               upstream_in_data,
    input  logic                                    upstream_in_valid,
    output logic                                    upstream_in_ready,
    output logic [`HUB_MSG_WIDTH-1:0]               upstream_out_data,
    output logic                                    upstream_out_valid,
    input  logic                                    upstream_out_ready,

    input  logic [`HUB_DOWN_COUNT*`HUB_MSG_WIDTH-1:0] downstream_in_data,
    input  logic [`HUB_DOWN_COUNT-1:0]              downstream_in_valid,
    output logic [`HUB_DOWN_COUNT-1:0]              downstream_in_ready,
    output logic [`HUB_DOWN_COUNT*`HUB_MSG_WIDTH-1:0] downstream_out_data,
    output logic [`HUB_DOWN_COUNT-1:0]              downstream_out_valid,
    input  logic [`HUB_DOWN_COUNT-1:0]              downstream_out_ready,

    input  logic [`HUB_DOWN_COUNT-1:0]              downstream_has_odd_clusters,
    input  logic [`HUB_DOWN_COUNT-1:0]              downstream_has_message_flying,
    output logic                                    upstream_has_odd_clusters,
    output logic                                    upstream_has_message_flying
);

    localparam int DOWN = `HUB_DOWN_COUNT;
    localparam int W    = `HUB_MSG_WIDTH;

    hub_sel_if sel_bus ();

    hub_msg_pkg::hub_msg_t    up_head;
    logic                     up_head_valid;
    logic                     up_taken;
    hub_msg_pkg::hub_msg_t    down_head [DOWN];
    logic [DOWN-1:0]          down_head_valid;
    logic [DOWN-1:0]          down_taken;
    // top bit is the upstream buffer
    logic [DOWN:0]            buf_empty;
    hub_msg_pkg::hub_msg_t    out_msg;
    hub_route_pkg::hub_dest_t out_dest;
    logic                     all_ready;
    logic                     hub_busy;

    hub_input_buffer u_up_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (upstream_in_data),
        .in_valid  (upstream_in_valid),
        .in_ready  (upstream_in_ready),
        .out_data  (up_head),
        .out_valid (up_head_valid),
        .out_taken (up_taken),
        .empty     (buf_empty[DOWN])
    );

    for (genvar i = 0; i < DOWN; i++) begin : g_down_buf
        hub_input_buffer u_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_data   (downstream_in_data[i*W +: W]),
            .in_valid  (downstream_in_valid[i]),
            .in_ready  (downstream_in_ready[i]),
            .out_data  (down_head[i]),
            .out_valid (down_head_valid[i]),
            .out_taken (down_taken[i]),
            .empty     (buf_empty[i])
        );
    end

    hub_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_data    (up_head),
        .up_valid   (up_head_valid),
        .up_taken   (up_taken),
        .down_data  (down_head),
        .down_valid (down_head_valid),
        .down_taken (down_taken),
        .sel        (sel_bus.arb_mp)
    );

    assign all_ready = (&downstream_out_ready) & upstream_out_ready;
    // anything sitting in a buffer, the selection or the output stage
    assign hub_busy  = ~(&buf_empty) | sel_bus.valid | (|out_dest);

    hub_router u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .sel         (sel_bus.rtr_mp),
        .all_ready   (all_ready),
        .out_msg     (out_msg),
        .out_dest    (out_dest),
        .down_odd    (downstream_has_odd_clusters),
        .down_flying (downstream_has_message_flying),
        .hub_busy    (hub_busy),
        .up_odd      (upstream_has_odd_clusters),
        .up_flying   (upstream_has_message_flying)
    );

    // same word on every link, the mask picks who sees it
    for (genvar i = 0; i < DOWN; i++) begin : g_fanout
        assign downstream_out_data[i*W +: W] = out_msg;
    end

    assign downstream_out_valid = out_dest[DOWN-1:0];
    assign upstream_out_data    = out_msg;
    assign upstream_out_valid   = out_dest[DOWN];

endmodule

// File: verification/fpga_hub_properties.sv
`include "hub_settings.svh"

module fpga_hub_properties (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic [`HUB_MSG_WIDTH-1:0]                 upstream_out_data,
    input logic                                      upstream_out_valid,
    input logic                                      upstream_out_ready,
    input logic [`HUB_DOWN_COUNT*`HUB_MSG_WIDTH-1:0] downstream_out_data,
    input logic [`HUB_DOWN_COUNT-1:0]                downstream_out_valid,
    input logic [`HUB_DOWN_COUNT-1:0]                downstream_out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `HUB_MSG_WIDTH;
    localparam int D = `HUB_DOWN_COUNT;

    logic [D:0] valid_set;

    assign valid_set = {upstream_out_valid, downstream_out_valid};

    // broadcast to every leaf, or a single link
    a_valid_shape: assert property (@(posedge clk) disable iff (!rst_n)
        valid_set == {1'b0, {D{1'b1}}} || $onehot0(valid_set))
        else $error("output valid set is neither a broadcast nor a single link");

    a_up_hold: assert property (@(posedge clk) disable iff (!rst_n)
        upstream_out_valid && !upstream_out_ready
        |=> upstream_out_valid && $stable(upstream_out_data))
        else $error("upstream link dropped or changed a pending word");

    for (genvar i = 0; i < D; i++) begin : g_down_hold
        a_down_hold: assert property (@(posedge clk) disable iff (!rst_n)
            downstream_out_valid[i] && !downstream_out_ready[i]
            |=> downstream_out_valid[i] && $stable(downstream_out_data[i*W +: W]))
            else $error("downstream link %0d dropped or changed a pending word", i);
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> valid_set == '0)
        else $error("an output valid is high right after reset");

endmodule

bind fpga_hub fpga_hub_properties u_properties (
    .clk                  (clk),
    .rst_n                (rst_n),
    .upstream_out_data    (upstream_out_data),
    .upstream_out_valid   (upstream_out_valid),
    .upstream_out_ready   (upstream_out_ready),
    .downstream_out_data  (downstream_out_data),
    .downstream_out_valid (downstream_out_valid),
    .downstream_out_ready (downstream_out_ready)
);

// File: verification/fpga_hub_tb.sv
`include "hub_settings.svh"

module fpga_hub_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W          = `HUB_MSG_WIDTH;
    localparam int D          = `HUB_DOWN_COUNT;
    localparam int DEPTH      = `HUB_BUF_DEPTH;
    localparam int FIRST_ID   = `HUB_FIRST_PORT_ID;
    localparam int IDS_PER_PORT = `HUB_IDS_PER_PORT;
    localparam int NUM_MSGS   = 2000;
    localparam int MAX_CYCLES = NUM_MSGS * 10;
    localparam int MODE_IDLE   = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_FILL   = 2;

    // index D is the upstream link, 0 to D-1 the leaf links
    logic                  clk = 1'b0;
    logic                  rst_n;
    hub_msg_pkg::hub_msg_t in_data [D+1];
    logic [D:0]            in_valid;
    logic [D:0]            out_ready;
    logic [D-1:0]          down_odd;
    logic [D-1:0]          down_flying;
    wire  [D:0]            in_ready;
    wire  [D:0]            out_valid;
    wire  [W-1:0]          out_data [D+1];
    wire  [D*W-1:0]        down_in_bus;
    wire  [D*W-1:0]        down_out_bus;
    wire                   up_odd;
    wire                   up_flying;

    // expected traffic held in one queue per source link and output port
    hub_msg_pkg::hub_msg_t model_q [D+1][D+1][$];
    logic [D:0]            accepted;
    int                    acc_count [D+1];
    int                    in_hub = 0;
    int                    total_accepted = 0;
    int                    cycle_count = 0;
    logic                  exp_odd;
    logic                  exp_flying;

    for (genvar i = 0; i < D; i++) begin : g_link
        assign down_in_bus[i*W +: W] = in_data[i];
        assign out_data[i] = down_out_bus[i*W +: W];
    end

    fpga_hub dut (
        .clk                           (clk),
        .rst_n                         (rst_n),
        .upstream_in_data              (in_data[D]),
        .upstream_in_valid             (in_valid[D]),
        .upstream_in_ready             (in_ready[D]),
        .upstream_out_data             (out_data[D]),
        .upstream_out_valid            (out_valid[D]),
        .upstream_out_ready            (out_ready[D]),
        .downstream_in_data            (down_in_bus),
        .downstream_in_valid           (in_valid[D-1:0]),
        .downstream_in_ready           (in_ready[D-1:0]),
        .downstream_out_data           (down_out_bus),
        .downstream_out_valid          (out_valid[D-1:0]),
        .downstream_out_ready          (out_ready[D-1:0]),
        .downstream_has_odd_clusters   (down_odd),
        .downstream_has_message_flying (down_flying),
        .upstream_has_odd_clusters     (up_odd),
        .upstream_has_message_flying   (up_flying)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            stop_on_error($sformatf("ERROR: timeout, run did not end within %0d cycles",
                MAX_CYCLES));
        end
    end

    // control ids go often, and half of all ids lie outside every port range
    function automatic hub_msg_pkg::hub_msg_t random_msg();
        hub_msg_pkg::hub_msg_t m;
        m = W'($urandom);
        if ($urandom_range(2) == 0) begin
            m.fifo_id = '1;
        end
        return m;
    endfunction

    // leaf port k owns IDS_PER_PORT ids starting at FIRST_ID + k * IDS_PER_PORT
    function automatic logic [D:0] expected_dest(input int src, input hub_msg_pkg::hub_msg_t m);
        logic [D:0] dest;
        int         id;
        id   = int'(m.dest_fpga_id);
        dest = '0;
        if (m.fifo_id != '1) begin
            if (id >= FIRST_ID && id < FIRST_ID + D * IDS_PER_PORT) begin
                dest[(id - FIRST_ID) / IDS_PER_PORT] = 1'b1;
            end else begin
                dest[D] = 1'b1;
            end
        end else if (src == D) begin
            dest = {1'b0, {D{1'b1}}};
        end else begin
            dest = {1'b1, {D{1'b0}}};
        end
        return dest;
    endfunction

    function automatic void record_input(input int src, input hub_msg_pkg::hub_msg_t m);
        logic [D:0] dest;
        dest = expected_dest(src, m);
        for (int p = 0; p <= D; p++) begin
            if (dest[p]) begin
                model_q[src][p].push_back(m);
            end
        end
    endfunction

    task automatic check_output(input int p, input hub_msg_pkg::hub_msg_t m);
        logic found;
        found = 1'b0;
        for (int s = 0; s <= D; s++) begin
            if (!found && model_q[s][p].size() > 0 && model_q[s][p][0] == m) begin
                found = 1'b1;
                void'(model_q[s][p].pop_front());
            end
        end
        assert (found) else stop_on_error($sformatf(
            "FAIL at %0t ns: port %0d sent unexpected message %h", $time, p, m));
        if (m.fifo_id == '1 && p < D) begin
            assert (out_valid == {1'b0, {D{1'b1}}}) else stop_on_error($sformatf(
                "FAIL at %0t ns: broadcast left on links %b", $time, out_valid));
        end else if (m.fifo_id == '1) begin
            assert (out_valid == {1'b1, {D{1'b0}}}) else stop_on_error($sformatf(
                "FAIL at %0t ns: leaf control message on links %b", $time, out_valid));
        end else begin
            assert ($onehot(out_valid)) else stop_on_error($sformatf(
                "FAIL at %0t ns: routed message on links %b", $time, out_valid));
        end
    endtask

    // scoreboard sampled on the rising edge where all inputs are settled
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_odd    = 1'b0;
            exp_flying = 1'b0;
            in_hub     = 0;
            accepted   = '0;
        end else begin
            assert (up_odd == exp_odd && up_flying == exp_flying) else stop_on_error(
                $sformatf("FAIL at %0t ns: status odd=%b flying=%b, expected %b %b",
                $time, up_odd, up_flying, exp_odd, exp_flying));
            exp_odd    = |down_odd;
            exp_flying = (|down_flying) || (in_hub != 0);
            // every output shares one ready, so a valid word leaves on this edge
            if (out_ready[0] && (|out_valid)) begin
                for (int p = 0; p <= D; p++) begin
                    if (out_valid[p]) begin
                        check_output(p, out_data[p]);
                    end
                end
                in_hub--;
            end
            accepted = in_valid & in_ready;
            for (int s = 0; s <= D; s++) begin
                if (accepted[s]) begin
                    record_input(s, in_data[s]);
                    acc_count[s]++;
                    total_accepted++;
                    in_hub++;
                end
            end
        end
    end

    // a source keeps its word until the hub takes it
    task automatic drive_inputs(input int mode);
        for (int i = 0; i <= D; i++) begin
            if (mode == MODE_IDLE) begin
                in_valid[i] = 1'b0;
            end else if (!in_valid[i] || accepted[i]) begin
                in_valid[i] = (mode == MODE_FILL) || ($urandom_range(5) == 0);
                in_data[i]  = random_msg();
            end
        end
        out_ready   = (mode == MODE_FILL) ? '0 : (($urandom_range(7) != 0) ? '1 : '0);
        down_odd    = ($urandom_range(3) == 0) ? D'($urandom) : '0;
        down_flying = ($urandom_range(3) == 0) ? D'($urandom) : '0;
    endtask

    task automatic drain_hub();
        do begin
            @(negedge clk);
            drive_inputs(MODE_IDLE);
        end while (in_hub != 0);
        for (int s = 0; s <= D; s++) begin
            for (int p = 0; p <= D; p++) begin
                assert (model_q[s][p].size() == 0) else stop_on_error($sformatf(
                    "ERROR: %0d messages from link %0d never reached port %0d",
                    model_q[s][p].size(), s, p));
            end
        end
    endtask

    initial begin
        void'($urandom(32'he6cf));
        rst_n       = 1'b0;
        in_valid    = '0;
        out_ready   = '1;
        down_odd    = '0;
        down_flying = '0;
        for (int i = 0; i <= D; i++) begin
            in_data[i]   = '0;
            acc_count[i] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (total_accepted < NUM_MSGS) begin
            @(negedge clk);
            drive_inputs(MODE_RANDOM);
        end
        drain_hub();

        // outputs stalled with an empty pipeline, so each buffer takes DEPTH words
        for (int i = 0; i <= D; i++) begin
            acc_count[i] = 0;
        end
        repeat (DEPTH + 4) begin
            @(negedge clk);
            drive_inputs(MODE_FILL);
        end
        assert (in_ready == '0) else stop_on_error($sformatf(
            "FAIL at %0t ns: in_ready %b still high with outputs stalled", $time, in_ready));
        for (int i = 0; i <= D; i++) begin
            assert (acc_count[i] == DEPTH) else stop_on_error($sformatf(
                "FAIL at %0t ns: link %0d took %0d words while stalled", $time, i,
                acc_count[i]));
        end
        drain_hub();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: fpga_hub.f
+incdir+source
source/hub_msg_pkg.sv
source/hub_route_pkg.sv
source/hub_sel_if.sv
source/hub_input_buffer.sv
source/hub_arbiter.sv
source/hub_router.sv
source/fpga_hub.sv
verification/fpga_hub_properties.sv
verification/fpga_hub_tb.sv

// File: Bender.yml
package:
  name: fpga_hub

sources:
  - include_dirs:
      - source
    files:
      - source/hub_msg_pkg.sv
      - source/hub_route_pkg.sv
      - source/hub_sel_if.sv
      - source/hub_input_buffer.sv
      - source/hub_arbiter.sv
      - source/hub_router.sv
      - source/fpga_hub.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/fpga_hub_properties.sv
      - verification/fpga_hub_tb.sv
